/* logic/dcache_pkg.sv */
package dcache_pkg;

    localparam int DATA_WIDTH  = 32;   // Word width, size decode assumes 4 bytes
    localparam int BE_WIDTH    = 4;    // One strobe per byte
    localparam int OFFSET_BITS = 2;    // Byte offset, ignored by the cache

    // Decoded CPU byte enable
    typedef enum logic [1:0] {
        SIZE_BYTE,   // 0001
        SIZE_HALF,   // 0011
        SIZE_WORD,   // 1111
        SIZE_BAD     // Anything else, answered with an error
    } access_size_e;

    // Controller FSM
    typedef enum logic [2:0] {
        ST_IDLE,       // Waiting for a CPU request
        ST_LOOKUP,     // Tag compare on the latched address
        ST_MEM_REQ,    // Line fetch request to memory
        ST_MEM_WAIT,   // Waiting for fetched word
        ST_WT_REQ,     // Write-through to memory
        ST_RESP        // One-cycle CPU response
    } ctrl_state_e;

endpackage

/* logic/dcache_store.sv */
`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int NUM_SETS   = 256,
    parameter int NUM_WAYS   = 4
) (
    input  logic                                               clk,
    input  logic                                               rst_n_i,
    input  logic [$clog2(NUM_SETS)-1:0]                        set_i,       // Set index
    input  logic [ADDR_WIDTH-$clog2(NUM_SETS)-OFFSET_BITS-1:0] tag_i,       // Lookup and fill tag
    input  logic                                               wr_en_i,     // Install strobe
    input  logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] wr_way_i,    // Way to install into
    input  logic [DATA_WIDTH-1:0]                              wr_word_i,   // Word to install
    output logic                                               hit_o,
    output logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] hit_way_o,
    output logic [DATA_WIDTH-1:0]                              hit_word_o,
    output logic [NUM_WAYS-1:0]                                valid_vec_o  // Valid bits of set_i
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - OFFSET_BITS;   // 22 for the default geometry
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Line storage, one word per line
    logic [TAG_W-1:0]      tag_q   [NUM_SETS][NUM_WAYS];
    logic [DATA_WIDTH-1:0] data_q  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]   valid_q [NUM_SETS];             // Only state with a reset

    logic [NUM_WAYS-1:0]   hit_vec;                        // Per-way match

    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (wr_en_i) begin
            valid_q[set_i][wr_way_i] <= 1'b1;   // Installed line becomes valid
        end
    end

    // Tag and data write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[set_i][wr_way_i]  <= tag_i;
            data_q[set_i][wr_way_i] <= wr_word_i;
        end
    end

    // Parallel compare over all ways
    always_comb begin
        hit_vec    = '0;
        hit_way_o  = '0;
        hit_word_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[set_i][w] && (tag_q[set_i][w] == tag_i)) begin
                hit_vec[w] = 1'b1;
                hit_way_o  = WAY_W'(w);
                hit_word_o = data_q[set_i][w];   // Hit word mux
            end
        end
    end

    assign hit_o       = |hit_vec;
    assign valid_vec_o = valid_q[set_i];   // Feeds victim choice

    // Fills only go to a missing tag, so a tag lives in one way
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(hit_vec)
    ) else $error("More than one way hits in set %0d", set_i);

endmodule

/* logic/dcache_lru.sv */
`timescale 1ns/1ps

module dcache_lru #(
    parameter int NUM_SETS = 256,
    parameter int NUM_WAYS = 4
) (
    input  logic                                               clk,
    input  logic                                               rst_n_i,
    input  logic [$clog2(NUM_SETS)-1:0]                        set_i,         // Set being accessed
    input  logic                                               touch_i,       // Hit or fill
    input  logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] touch_way_i,
    input  logic [NUM_WAYS-1:0]                                valid_vec_i,   // From the store
    output logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] victim_way_o
);

    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int AGE_W = WAY_W;   // Holds 0 to NUM_WAYS-1
    localparam logic [AGE_W-1:0] AGE_MAX = AGE_W'(NUM_WAYS - 1);

    logic [AGE_W-1:0] age_q [NUM_SETS][NUM_WAYS];   // Saturating age per way
    logic             inv_found;                    // An invalid way exists
    logic             old_found;                    // A way at max age exists

    // Touched way youngest, the rest age up to saturation
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_W'(w) == touch_way_i)
                    age_q[set_i][w] <= '0;
                else if (age_q[set_i][w] < AGE_MAX)
                    age_q[set_i][w] <= age_q[set_i][w] + 1'b1;
            end
        end
    end

    // Victim: lowest invalid way, else lowest oldest, else way 0
    always_comb begin
        inv_found    = 1'b0;
        old_found    = 1'b0;
        victim_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!valid_vec_i[w] && !inv_found) begin
                inv_found    = 1'b1;
                victim_way_o = WAY_W'(w);
            end
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!inv_found && !old_found && (age_q[set_i][w] == AGE_MAX)) begin
                old_found    = 1'b1;
                victim_way_o = WAY_W'(w);
            end
        end
    end

    // Touch way comes from the store or the captured victim
    a_touch_way_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        touch_i |-> (int'(touch_way_i) < NUM_WAYS)
    ) else $error("Touch on nonexistent way %0d", touch_way_i);

endmodule

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int NUM_SETS   = 256,
    parameter int NUM_WAYS   = 4
) (
    input  logic                                               clk,
    input  logic                                               rst_n_i,
    // CPU request
    input  logic                                               req_valid_i,
    input  logic                                               req_we_i,
    input  logic [ADDR_WIDTH-1:0]                              req_addr_i,
    input  logic [DATA_WIDTH-1:0]                              req_wdata_i,
    input  logic [BE_WIDTH-1:0]                                req_be_i,
    output logic                                               req_ready_o,
    // CPU response, no back-pressure
    output logic                                               rsp_valid_o,
    output logic [DATA_WIDTH-1:0]                              rsp_rdata_o,
    output logic                                               rsp_hit_o,
    output logic                                               rsp_err_o,
    // Memory port
    output logic                                               mem_req_valid_o,
    output logic                                               mem_req_we_o,
    output logic [ADDR_WIDTH-1:0]                              mem_req_addr_o,
    output logic [DATA_WIDTH-1:0]                              mem_req_wdata_o,
    output logic [BE_WIDTH-1:0]                                mem_req_be_o,
    input  logic                                               mem_req_ready_i,
    input  logic                                               mem_rsp_valid_i,
    input  logic [DATA_WIDTH-1:0]                              mem_rsp_rdata_i,
    // Store
    output logic [$clog2(NUM_SETS)-1:0]                        st_set_o,
    output logic [ADDR_WIDTH-$clog2(NUM_SETS)-OFFSET_BITS-1:0] st_tag_o,
    output logic                                               st_wr_o,
    output logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] st_way_o,
    output logic [DATA_WIDTH-1:0]                              st_word_o,
    input  logic                                               st_hit_i,
    input  logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] st_hit_way_i,
    input  logic [DATA_WIDTH-1:0]                              st_word_i,
    // Replacement
    output logic                                               lru_touch_o,
    output logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] lru_way_o,
    input  logic [((NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1)-1:0] victim_way_i
);

    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int WAY_W  = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int LINE_W = ADDR_WIDTH - OFFSET_BITS;   // Word address width

    ctrl_state_e           state_q;
    access_size_e          req_size;      // Decoded req_be_i
    access_size_e          size_q;
    logic                  we_q;
    logic [LINE_W-1:0]     line_addr_q;   // Offset bits dropped
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [BE_WIDTH-1:0]   be_q;
    logic [WAY_W-1:0]      way_q;         // Victim captured on a miss
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  hit_q;
    logic                  err_q;
    logic                  lookup_hit;    // Good request that hits

    // Overlay the strobed bytes of new_w on old_w
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0] old_w,
        input logic [DATA_WIDTH-1:0] new_w,
        input logic [BE_WIDTH-1:0]   be
    );
        logic [DATA_WIDTH-1:0] res;
        res = old_w;
        for (int b = 0; b < BE_WIDTH; b++) begin
            if (be[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // Read data zero-extended by access size
    function automatic logic [DATA_WIDTH-1:0] zero_ext(
        input logic [DATA_WIDTH-1:0] w,
        input access_size_e          size
    );
        case (size)
            SIZE_BYTE: return {24'b0, w[7:0]};
            SIZE_HALF: return {16'b0, w[15:0]};
            SIZE_WORD: return w;
            default:   return '0;
        endcase
    endfunction

    always_comb begin
        case (req_be_i)
            4'b0001: req_size = SIZE_BYTE;
            4'b0011: req_size = SIZE_HALF;
            4'b1111: req_size = SIZE_WORD;
            default: req_size = SIZE_BAD;
        endcase
    end

    assign lookup_hit = (state_q == ST_LOOKUP) && st_hit_i && (size_q != SIZE_BAD);

    // FSM
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:
                    if (req_valid_i)
                        state_q <= ST_LOOKUP;
                ST_LOOKUP:
                    if (size_q == SIZE_BAD)
                        state_q <= ST_RESP;          // Error, nothing touched
                    else if (!st_hit_i)
                        state_q <= ST_MEM_REQ;       // Allocate on read and write
                    else if (we_q)
                        state_q <= ST_WT_REQ;
                    else
                        state_q <= ST_RESP;
                ST_MEM_REQ:
                    if (mem_req_ready_i)
                        state_q <= ST_MEM_WAIT;
                ST_MEM_WAIT:
                    if (mem_rsp_valid_i)
                        state_q <= we_q ? ST_WT_REQ : ST_RESP;
                ST_WT_REQ:
                    if (mem_req_ready_i)
                        state_q <= ST_RESP;
                default:
                    state_q <= ST_IDLE;              // ST_RESP lasts one cycle
            endcase
        end
    end

    // Request and response registers
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_valid_i) begin
            we_q        <= req_we_i;
            line_addr_q <= req_addr_i[ADDR_WIDTH-1:OFFSET_BITS];
            wdata_q     <= req_wdata_i;
            be_q        <= req_be_i;
            size_q      <= req_size;
        end
        if (state_q == ST_LOOKUP) begin
            hit_q   <= lookup_hit;
            err_q   <= (size_q == SIZE_BAD);
            rdata_q <= (st_hit_i && !we_q) ? zero_ext(st_word_i, size_q) : '0;
            way_q   <= victim_way_i;                 // Stable until the fill
        end
        if (state_q == ST_MEM_WAIT && mem_rsp_valid_i && !we_q)
            rdata_q <= zero_ext(mem_rsp_rdata_i, size_q);
    end

    // Store index from the latched address
    assign st_set_o = line_addr_q[IDX_W-1:0];
    assign st_tag_o = line_addr_q[LINE_W-1:IDX_W];

    // Write hit merges in place, fill installs the fetched word
    always_comb begin
        st_wr_o   = lookup_hit && we_q;
        st_way_o  = st_hit_way_i;
        st_word_o = merge_bytes(st_word_i, wdata_q, be_q);
        if (state_q == ST_MEM_WAIT) begin
            st_wr_o   = mem_rsp_valid_i;
            st_way_o  = way_q;
            st_word_o = we_q ? merge_bytes(mem_rsp_rdata_i, wdata_q, be_q) : mem_rsp_rdata_i;
        end
    end

    // Touch on every hit and every fill
    assign lru_touch_o = lookup_hit || (state_q == ST_MEM_WAIT && mem_rsp_valid_i);
    assign lru_way_o   = st_way_o;

    // Memory side, fetch is a full word read
    assign mem_req_valid_o = (state_q == ST_MEM_REQ) || (state_q == ST_WT_REQ);
    assign mem_req_we_o    = (state_q == ST_WT_REQ);
    assign mem_req_addr_o  = {line_addr_q, {OFFSET_BITS{1'b0}}};
    assign mem_req_wdata_o = wdata_q;
    assign mem_req_be_o    = (state_q == ST_WT_REQ) ? be_q : {BE_WIDTH{1'b1}};

    assign req_ready_o = (state_q == ST_IDLE);
    assign rsp_valid_o = (state_q == ST_RESP);
    assign rsp_rdata_o = rdata_q;
    assign rsp_hit_o   = hit_q;
    assign rsp_err_o   = err_q;

    // Memory request held until taken
    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (mem_req_valid_o && !mem_req_ready_i) |=>
            (mem_req_valid_o && $stable(mem_req_we_o) && $stable(mem_req_addr_o)
             && $stable(mem_req_wdata_o) && $stable(mem_req_be_o))
    ) else $error("Memory request changed under back-pressure");

    a_rsp_not_ready: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(rsp_valid_o && req_ready_o)
    ) else $error("Response while accepting a request");

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int NUM_SETS   = 256,
    parameter int NUM_WAYS   = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,       // CPU request
    input  logic                  req_we_i,
    input  logic [ADDR_WIDTH-1:0] req_addr_i,
    input  logic [DATA_WIDTH-1:0] req_wdata_i,
    input  logic [BE_WIDTH-1:0]   req_be_i,
    output logic                  req_ready_o,
    output logic                  rsp_valid_o,       // CPU response pulse
    output logic [DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                  rsp_hit_o,
    output logic                  rsp_err_o,
    output logic                  mem_req_valid_o,   // Backing memory
    output logic                  mem_req_we_o,
    output logic [ADDR_WIDTH-1:0] mem_req_addr_o,
    output logic [DATA_WIDTH-1:0] mem_req_wdata_o,
    output logic [BE_WIDTH-1:0]   mem_req_be_o,
    input  logic                  mem_req_ready_i,
    input  logic                  mem_rsp_valid_i,
    input  logic [DATA_WIDTH-1:0] mem_rsp_rdata_i
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - OFFSET_BITS;
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Controller to store
    logic [IDX_W-1:0]      st_set;
    logic [TAG_W-1:0]      st_tag;
    logic                  st_wr;
    logic [WAY_W-1:0]      st_way;
    logic [DATA_WIDTH-1:0] st_word;
    // Store to controller and LRU
    logic                  st_hit;
    logic [WAY_W-1:0]      st_hit_way;
    logic [DATA_WIDTH-1:0] st_hit_word;
    logic [NUM_WAYS-1:0]   st_valid_vec;
    // Replacement
    logic                  lru_touch;
    logic [WAY_W-1:0]      lru_way;
    logic [WAY_W-1:0]      victim_way;

    dcache_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS)
    ) dcache_ctrl_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_we_i        (req_we_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_be_i        (req_be_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_rdata_o     (rsp_rdata_o),
        .rsp_hit_o       (rsp_hit_o),
        .rsp_err_o       (rsp_err_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_we_o    (mem_req_we_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_req_be_o    (mem_req_be_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .st_set_o        (st_set),
        .st_tag_o        (st_tag),
        .st_wr_o         (st_wr),
        .st_way_o        (st_way),
        .st_word_o       (st_word),
        .st_hit_i        (st_hit),
        .st_hit_way_i    (st_hit_way),
        .st_word_i       (st_hit_word),
        .lru_touch_o     (lru_touch),
        .lru_way_o       (lru_way),
        .victim_way_i    (victim_way)
    );

    dcache_store #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS)
    ) dcache_store_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .set_i       (st_set),
        .tag_i       (st_tag),
        .wr_en_i     (st_wr),
        .wr_way_i    (st_way),
        .wr_word_i   (st_word),
        .hit_o       (st_hit),
        .hit_way_o   (st_hit_way),
        .hit_word_o  (st_hit_word),
        .valid_vec_o (st_valid_vec)
    );

    dcache_lru #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) dcache_lru_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .set_i        (st_set),         // Same set as the store lookup
        .touch_i      (lru_touch),
        .touch_way_i  (lru_way),
        .valid_vec_i  (st_valid_vec),
        .victim_way_o (victim_way)
    );

endmodule

/* verif/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int NUM_SETS = 256;
    localparam int NUM_WAYS = 4;
    localparam int TIMEOUT  = 200;           // Cycles per wait
    localparam int NUM_OPS  = 3000;
    localparam logic [31:0] SEED = 32'd17;

    logic        clk             = 1'b0;
    logic        rst_n_i         = 1'b0;
    logic        req_valid_i     = 1'b0;
    logic        req_we_i        = 1'b0;
    logic [31:0] req_addr_i      = '0;
    logic [31:0] req_wdata_i     = '0;
    logic [3:0]  req_be_i        = '0;
    logic        mem_req_ready_i = 1'b0;
    logic        mem_rsp_valid_i = 1'b0;
    logic [31:0] mem_rsp_rdata_i = '0;
    logic        req_ready_o;
    logic        rsp_valid_o;
    logic [31:0] rsp_rdata_o;
    logic        rsp_hit_o;
    logic        rsp_err_o;
    logic        mem_req_valid_o;
    logic        mem_req_we_o;
    logic [31:0] mem_req_addr_o;
    logic [31:0] mem_req_wdata_o;
    logic [3:0]  mem_req_be_o;

    // Memory model state
    logic [31:0] mem_q [logic [29:0]];       // Sparse and keyed by word address
    logic [31:0] mem_rng   = SEED ^ 32'h9E37_79B9;
    int          stall_cnt = 0;              // Remaining forced ready-low cycles
    logic        rd_pend   = 1'b0;
    int          rd_delay  = 0;
    logic [29:0] rd_wa     = '0;
    int          rd_cnt    = 0;              // Accepted memory reads
    logic [31:0] wr_addr_q [$];              // Accepted memory writes
    logic [31:0] wr_data_q [$];
    logic [3:0]  wr_be_q   [$];

    // Reference model
    logic [31:0] ref_mem_q [logic [29:0]];
    logic        ref_valid [NUM_SETS][NUM_WAYS];
    logic [21:0] ref_tag   [NUM_SETS][NUM_WAYS];
    int          ref_age   [NUM_SETS][NUM_WAYS];
    logic [31:0] stim_rng = SEED;
    logic [21:0] tag_pool [6] = '{22'h000012, 22'h1ABC03, 22'h3FFFFF,
                                  22'h000000, 22'h2B0440, 22'h155A5A};
    logic [7:0]  set_pool [4] = '{8'h00, 8'h3C, 8'h7F, 8'hC5};

    always #50 clk = ~clk;

    dcache_top #(
        .ADDR_WIDTH (32),
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS)
    ) dcache_top_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Contents of never written memory words
    function automatic logic [31:0] fill_pattern(input logic [29:0] wa);
        return {wa[13:0], wa[29:12]} ^ (32'(wa) * 32'h9E37_79B1);
    endfunction

    function automatic logic [31:0] mem_word(input logic [29:0] wa);
        return mem_q.exists(wa) ? mem_q[wa] : fill_pattern(wa);
    endfunction

    function automatic logic [31:0] ref_word(input logic [29:0] wa);
        return ref_mem_q.exists(wa) ? ref_mem_q[wa] : fill_pattern(wa);
    endfunction

    // Byte lanes with a strobe take the new data
    function automatic logic [31:0] strobe_write(input logic [31:0] old_w,
                                                 input logic [31:0] new_w,
                                                 input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};   // One byte per strobe
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic access_size_e size_of(input logic [3:0] be);
        if (be == 4'b0001) return SIZE_BYTE;
        if (be == 4'b0011) return SIZE_HALF;
        if (be == 4'b1111) return SIZE_WORD;
        return SIZE_BAD;
    endfunction

    function automatic logic [31:0] size_mask(input access_size_e size);
        if (size == SIZE_BYTE) return 32'h0000_00FF;
        if (size == SIZE_HALF) return 32'h0000_FFFF;
        if (size == SIZE_WORD) return 32'hFFFF_FFFF;
        return 32'h0;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
        $display("*** FAILED ***");
        $fatal(1, "Wait timed out");
    endtask

    // Hit or fill way goes to age 0 and the others saturate at NUM_WAYS-1
    task automatic model_access(input logic [7:0] set, input logic [21:0] tag, output logic hit);
        int way;
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag)
                way = w;
        end
        hit = (way >= 0);
        if (!hit) begin
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[set][w])
                    way = w;                     // Lowest invalid way
            end
            if (way < 0) begin
                way = 0;                         // No way at max age
                for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                    if (ref_age[set][w] == NUM_WAYS - 1)
                        way = w;
                end
            end
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = tag;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (w == way)
                ref_age[set][w] = 0;
            else if (ref_age[set][w] < NUM_WAYS - 1)
                ref_age[set][w] = ref_age[set][w] + 1;
        end
    endtask

    // One CPU request issued right after a rising edge
    task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be, output logic got_hit);
        access_size_e size;
        logic [29:0]  wa;
        logic         exp_hit;
        logic         exp_err;
        logic [31:0]  exp_rdata;
        int           rd_base;
        int           t;
        int           lat;
        wa        = addr[31:2];
        size      = size_of(be);
        exp_err   = (size == SIZE_BAD);
        exp_hit   = 1'b0;
        exp_rdata = '0;
        if (!exp_err) begin
            model_access(addr[9:2], addr[31:10], exp_hit);
            if (we)
                ref_mem_q[wa] = strobe_write(ref_word(wa), wdata, be);
            else
                exp_rdata = ref_word(wa) & size_mask(size);   // Zero-extended
        end
        rd_base = rd_cnt;
        req_valid_i <= 1'b1;
        req_we_i    <= we;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        req_be_i    <= be;
        t = 0;
        @(posedge clk);
        while (!req_ready_o) begin
            t++;
            if (t > TIMEOUT)
                report_timeout("the cache to accept a request");
            @(posedge clk);
        end
        req_valid_i <= 1'b0;                     // Taken on this edge
        lat = 1;
        @(posedge clk);
        while (!rsp_valid_o) begin
            if (lat > TIMEOUT)
                report_timeout("a CPU response");
            @(posedge clk);
            lat++;
        end
        check_eq("rsp_err_o", 32'(rsp_err_o), 32'(exp_err));
        check_eq("rsp_hit_o", 32'(rsp_hit_o), 32'(exp_hit));
        if (!we || exp_err)
            check_eq("rsp_rdata_o", rsp_rdata_o, exp_rdata);
        if (exp_err || (exp_hit && !we))
            check_eq("response_latency", 32'(lat), 32'd2);   // Fixed two-cycle path
        check_eq("mem_read_count", 32'(rd_cnt - rd_base), (!exp_err && !exp_hit) ? 32'd1 : 32'd0);
        if (we && !exp_err) begin
            check_eq("mem_write_count", 32'(wr_addr_q.size()), 32'd1);
            check_eq("mem_req_addr_o", wr_addr_q.pop_front(), {addr[31:2], 2'b00});
            check_eq("mem_req_wdata_o", wr_data_q.pop_front(), wdata);
            check_eq("mem_req_be_o", 32'(wr_be_q.pop_front()), 32'(be));
            check_eq("mem_word", mem_word(wa), ref_word(wa));
        end else begin
            check_eq("mem_write_count", 32'(wr_addr_q.size()), 32'd0);
        end
        got_hit = rsp_hit_o;
    endtask

    // Backing memory with random ready, stall stretches and read delay
    always @(posedge clk) begin
        mem_rng = xorshift(mem_rng);
        if (!rst_n_i) begin
            mem_req_ready_i <= 1'b0;
            mem_rsp_valid_i <= 1'b0;
            rd_pend   = 1'b0;
            stall_cnt = 0;
        end else begin
            mem_rsp_valid_i <= 1'b0;
            if (rd_pend) begin
                rd_delay--;
                if (rd_delay == 0) begin
                    mem_rsp_valid_i <= 1'b1;
                    mem_rsp_rdata_i <= mem_word(rd_wa);
                    rd_pend = 1'b0;
                end
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (mem_req_we_o) begin
                    mem_q[mem_req_addr_o[31:2]] = strobe_write(mem_word(mem_req_addr_o[31:2]),
                                                               mem_req_wdata_o, mem_req_be_o);
                    wr_addr_q.push_back(mem_req_addr_o);
                    wr_data_q.push_back(mem_req_wdata_o);
                    wr_be_q.push_back(mem_req_be_o);
                end else begin
                    rd_cnt++;
                    rd_pend  = 1'b1;
                    rd_delay = 1 + int'(mem_rng[9:8]);   // 1 to 4 cycles
                    rd_wa    = mem_req_addr_o[31:2];
                end
            end
            if (stall_cnt > 0) begin
                stall_cnt--;
                mem_req_ready_i <= 1'b0;
            end else if (mem_rng[4:0] == 5'd0) begin
                stall_cnt = 3 + int'(mem_rng[7:5]);       // Long back-pressure stretch
                mem_req_ready_i <= 1'b0;
            end else begin
                mem_req_ready_i <= mem_rng[10] | mem_rng[11];
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0]  be;
        logic        hit;
        int          hits;
        hits = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_age[s][w]   = 0;
            end
        end
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        check_eq("req_ready_o", 32'(req_ready_o), 32'd1);
        check_eq("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
        check_eq("mem_req_valid_o", 32'(mem_req_valid_o), 32'd0);

        // Five tags through one set evict the first one
        for (int i = 0; i < 5; i++)
            cpu_access(1'b0, {tag_pool[i], 8'hA0, 2'b00}, 32'h0, 4'b1111, hit);
        cpu_access(1'b0, {tag_pool[0], 8'hA0, 2'b00}, 32'h0, 4'b1111, hit);
        check_eq("evicted_tag_hit", 32'(hit), 32'd0);

        // Byte and half merges followed by a bad strobe
        addr = {tag_pool[1], 8'h55, 2'b00};
        cpu_access(1'b0, addr, 32'h0, 4'b1111, hit);
        cpu_access(1'b1, addr, 32'h1234_56AB, 4'b0001, hit);
        cpu_access(1'b0, addr, 32'h0, 4'b1111, hit);
        cpu_access(1'b1, addr, 32'h9876_CDEF, 4'b0011, hit);
        cpu_access(1'b0, addr, 32'h0, 4'b1111, hit);
        cpu_access(1'b1, addr, 32'hFFFF_FFFF, 4'b0101, hit);
        cpu_access(1'b0, addr, 32'h0, 4'b1111, hit);

        // Random mix over a small tag and set pool
        for (int i = 0; i < NUM_OPS; i++) begin
            stim_rng = xorshift(stim_rng);
            r = stim_rng;
            case (r[10:8])
                3'd0, 3'd1:       be = 4'b0001;
                3'd2, 3'd3:       be = 4'b0011;
                3'd4, 3'd5, 3'd6: be = 4'b1111;
                default: begin
                    be = r[15:12];
                    if (size_of(be) != SIZE_BAD)
                        be = 4'b0110;
                end
            endcase
            addr = {tag_pool[r % 6], set_pool[r[5:4]], r[18:17]};
            cpu_access(r[16], addr, xorshift(r), be, hit);
            if (hit)
                hits++;
        end
        $display("Random phase done, %0d of %0d accesses hit", hits, NUM_OPS);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* list.f */
logic/dcache_pkg.sv
logic/dcache_store.sv
logic/dcache_lru.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/dcache_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dcache_tb
FILELIST = list.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
